// ==== hw/commit_pkg.sv ====
package commit_pkg;

    localparam int WORD_W     = 32;
    localparam int REG_ADDR_W = 5;
    localparam int MEM_OP_W   = 3;

    typedef logic [WORD_W-1:0]     word_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;
    typedef logic [MEM_OP_W-1:0]   mem_op_t;

    // memory opcodes carried with each instruction
    localparam mem_op_t OP_NONE = 3'd0;
    localparam mem_op_t OP_LB   = 3'd1;
    localparam mem_op_t OP_LBU  = 3'd2;
    localparam mem_op_t OP_LH   = 3'd3;
    localparam mem_op_t OP_LHU  = 3'd4;
    localparam mem_op_t OP_LW   = 3'd5;
    localparam mem_op_t OP_SW   = 3'd6;

    // general exception vector with BEV=1
    localparam word_t EXC_ENTRY = 32'hbfc00380;

    typedef struct packed {
        logic    branch;
        logic    jump;
        logic    jr;
        logic    regwrite;
        logic    memtoreg;
        logic    memwrite;
        logic    eret;
        logic    tlb;
        mem_op_t mem_op;
    } ctl_t;

    // what fetch guessed for this instruction
    typedef struct packed {
        logic  taken;
        word_t destpc;
    } pred_t;

    typedef struct packed {
        ctl_t      ctl;
        pred_t     pred;
        logic      taken;
        word_t     pcplus4;
        word_t     pcbranch;
        word_t     pcjump;
        word_t     srca;
        reg_addr_t destreg;
        word_t     exec_result;
    } slot_t;

    typedef struct packed {
        logic  valid;
        word_t target;
    } redirect_t;

    typedef struct packed {
        logic  wen;
        word_t pc;
        logic  taken;
        word_t target;
    } bpu_update_t;

    typedef struct packed {
        logic       en;
        logic [1:0] size;
        word_t      addr;
        word_t      rdata;
        logic       data_ok;
    } mem_rsp_t;

    // index 1 is the older slot as on the input side
    typedef struct packed {
        logic      [1:0] wen;
        reg_addr_t [1:0] destreg;
        word_t     [1:0] result;
        logic      [1:0] ready;
    } bypass_t;

endpackage

// ==== hw/load_format.sv ====
`timescale 1ns/1ps

module load_format (
    input  commit_pkg::word_t   word,
    input  logic [1:0]          byte_sel,
    input  commit_pkg::mem_op_t op,
    output commit_pkg::word_t   value
);
    import commit_pkg::*;

    logic [7:0]  sel_byte;
    logic [15:0] sel_half;

    // little-endian lane select
    always_comb
    begin
        case (byte_sel)
            2'd0:    sel_byte = word[7:0];
            2'd1:    sel_byte = word[15:8];
            2'd2:    sel_byte = word[23:16];
            default: sel_byte = word[31:24];
        endcase
    end

    assign sel_half = byte_sel[1] ? word[31:16] : word[15:0];

    always_comb
    begin
        case (op)
            OP_LB:   value = {{24{sel_byte[7]}}, sel_byte};
            OP_LBU:  value = {24'd0, sel_byte};
            OP_LH:   value = {{16{sel_half[15]}}, sel_half};
            OP_LHU:  value = {16'd0, sel_half};
            OP_LW:   value = word;
            // stores and non-memory ops return nothing
            default: value = '0;
        endcase
    end

    // misaligned accesses should have trapped earlier as AdEL
    always_comb
    begin
        if (op == OP_LH || op == OP_LHU)
        begin
            assert final (byte_sel[0] == 1'b0)
                else $error("load_format: half load at odd offset %0d", byte_sel);
        end
        if (op == OP_LW)
        begin
            assert final (byte_sel == 2'd0)
                else $error("load_format: word load at offset %0d", byte_sel);
        end
    end

endmodule

// ==== hw/mem_response_hold.sv ====
`timescale 1ns/1ps

module mem_response_hold (
    input  logic              clk,
    input  logic              arst_n,
    input  logic              stall,
    input  logic              en,
    input  logic              data_ok,
    input  commit_pkg::word_t rdata,
    output commit_pkg::word_t rdata_eff,
    output logic              done
);
    import commit_pkg::*;

    logic  data_ok_q;
    word_t rdata_q;

    // keep the response until the stage is allowed to advance
    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            data_ok_q <= 1'b0;
            rdata_q   <= '0;
        end
        else if (!stall)
        begin
            data_ok_q <= 1'b0;
            rdata_q   <= '0;
        end
        else if (data_ok)
        begin
            data_ok_q <= 1'b1;
            rdata_q   <= rdata;
        end
    end

    // live word wins in the pulse cycle
    assign rdata_eff = data_ok ? rdata : rdata_q;
    assign done      = !en || data_ok || data_ok_q;

    // memory only answers an access that was issued
    assert property (@(posedge clk) disable iff (!arst_n) $rose(data_ok) |-> en)
        else $error("mem_response_hold: data_ok rose while en low");

endmodule

// ==== hw/redirect_unit.sv ====
`timescale 1ns/1ps

module redirect_unit (
    input  commit_pkg::slot_t [1:0] slots,
    input  logic                    exception_valid,
    input  commit_pkg::word_t       cp0_epc,
    output commit_pkg::redirect_t   redirect,
    output commit_pkg::bpu_update_t bpu_update,
    output logic                    tlb_ex
);
    import commit_pkg::*;

    ctl_t  ctl1;
    logic  eret_any;
    logic  branch_miss;
    logic  jr_miss;
    word_t branch_target;

    assign ctl1     = slots[1].ctl;
    assign eret_any = slots[1].ctl.eret | slots[0].ctl.eret;

    // only slot 1 can hold a control transfer; slot 0 is its delay slot
    assign branch_miss = ctl1.branch & (slots[1].taken != slots[1].pred.taken);
    assign jr_miss     = ctl1.jr &
                         (!slots[1].pred.taken || (slots[1].pred.destpc != slots[1].srca));

    // a predicted-taken branch that fell through resumes after the delay slot
    assign branch_target = slots[1].pred.taken ? slots[0].pcplus4 : slots[1].pcbranch;

    always_comb
    begin
        redirect.valid  = 1'b1;
        redirect.target = '0;
        if (exception_valid)
        begin
            redirect.target = EXC_ENTRY;
        end
        else if (eret_any)
        begin
            redirect.target = cp0_epc;
        end
        else if (branch_miss)
        begin
            redirect.target = branch_target;
        end
        else if (jr_miss)
        begin
            redirect.target = slots[1].srca;
        end
        else if (ctl1.tlb)
        begin
            // refetch so the new mapping is seen
            redirect.target = slots[1].pcplus4;
        end
        else
        begin
            redirect.valid = 1'b0;
        end
    end

    // predictor learns from slot-1 branches only
    assign bpu_update.wen    = ctl1.branch;
    assign bpu_update.pc     = slots[1].pcplus4 - word_t'(4);
    assign bpu_update.taken  = slots[1].taken;
    assign bpu_update.target = ctl1.jump ? slots[1].pcjump : slots[1].pcbranch;

    assign tlb_ex = ctl1.tlb;

    always_comb
    begin
        assert final (!(ctl1.eret && ctl1.branch))
            else $error("redirect_unit: eret and branch both set in slot 1");
    end

endmodule

// ==== hw/data_commit.sv ====
`timescale 1ns/1ps

module data_commit (
    input  logic                    clk,
    input  logic                    arst_n,
    input  logic                    stall,
    input  logic                    exception_valid,
    input  commit_pkg::slot_t [1:0] slots,
    input  commit_pkg::word_t       cp0_epc,
    input  commit_pkg::mem_rsp_t    mem,
    output commit_pkg::redirect_t   redirect,
    output commit_pkg::bpu_update_t bpu_update,
    output commit_pkg::bypass_t     bypass,
    output logic                    tlb_ex,
    output logic                    finish_cdata
);
    import commit_pkg::*;

    logic       [1:0] mem_access;
    logic             mem_slot;
    mem_op_t          mem_op;
    word_t            rdata_eff;
    word_t            load_value;
    word_t      [1:0] result;
    logic       [1:0] ready;

    assign mem_access[1] = slots[1].ctl.memtoreg | slots[1].ctl.memwrite;
    assign mem_access[0] = slots[0].ctl.memtoreg | slots[0].ctl.memwrite;

    // older slot has priority; otherwise slot 0 owns the port
    assign mem_slot = mem_access[1];
    assign mem_op   = slots[mem_slot].ctl.mem_op;

    mem_response_hold u_mem_response_hold (
        .clk       (clk),
        .arst_n    (arst_n),
        .stall     (stall),
        .en        (mem.en),
        .data_ok   (mem.data_ok),
        .rdata     (mem.rdata),
        .rdata_eff (rdata_eff),
        .done      (finish_cdata)
    );

    load_format u_load_format (
        .word     (rdata_eff),
        .byte_sel (mem.addr[1:0]),
        .op       (mem_op),
        .value    (load_value)
    );

    redirect_unit u_redirect_unit (
        .slots           (slots),
        .exception_valid (exception_valid),
        .cp0_epc         (cp0_epc),
        .redirect        (redirect),
        .bpu_update      (bpu_update),
        .tlb_ex          (tlb_ex)
    );

    // per-slot result and readiness, then pack the bypass bus
    always_comb
    begin
        for (int i = 0; i < 2; i++)
        begin
            result[i] = slots[i].ctl.memtoreg ? load_value : slots[i].exec_result;
            ready[i]  = !slots[i].ctl.memtoreg || finish_cdata;
        end
    end

    always_comb
    begin
        for (int i = 0; i < 2; i++)
        begin
            bypass.wen[i]     = slots[i].ctl.regwrite;
            bypass.destreg[i] = slots[i].destreg;
            bypass.result[i]  = result[i];
            bypass.ready[i]   = ready[i];
        end
    end

    // issue pairs at most one memory instruction
    assert property (@(posedge clk) disable iff (!arst_n) !(mem_access[1] && mem_access[0]))
        else $error("data_commit: both slots access memory");

endmodule

// ==== testbench/tb_data_commit.sv ====
`timescale 1ns/1ps

module tb_data_commit;
    import commit_pkg::*;

    localparam int CLK_PERIOD  = 100;
    localparam int SETTLE      = CLK_PERIOD / 4;
    // reset, load sweep, redirect, predictor, held response, pass-through
    localparam int TEST_CYCLES = 11 + 2 * 8 * 13 + 12 + 16 + 7 + 8;
    localparam int MARGIN      = 50;

    logic        clk;
    logic        arst_n;
    logic        stall;
    logic        exception_valid;
    slot_t [1:0] slots;
    word_t       cp0_epc;
    mem_rsp_t    mem;
    redirect_t   redirect;
    bpu_update_t bpu_update;
    bypass_t     bypass;
    logic        tlb_ex;
    logic        finish_cdata;

    logic [31:0] lfsr;
    int          errors;
    int          checks;
    int          tests_run;
    int          test_start;

    data_commit u_data_commit (
        .clk             (clk),
        .arst_n          (arst_n),
        .stall           (stall),
        .exception_valid (exception_valid),
        .slots           (slots),
        .cp0_epc         (cp0_epc),
        .mem             (mem),
        .redirect        (redirect),
        .bpu_update      (bpu_update),
        .bypass          (bypass),
        .tlb_ex          (tlb_ex),
        .finish_cdata    (finish_cdata)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // galois form of x^32 + x^22 + x^2 + x + 1
    function automatic logic next_bit();
        lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
        return lfsr[0];
    endfunction

    function automatic word_t rand_word(input int n);
        word_t v;
        v = '0;
        for (int i = 0; i < n; i++)
        begin
            v = {v[30:0], next_bit()};
        end
        return v;
    endfunction

    // reference extraction shifts the addressed lane down to bit 0
    function automatic word_t expect_load(input word_t w, input int off, input mem_op_t op);
        word_t sh;
        sh = w >> (8 * off);
        case (op)
            OP_LB:   return {{24{sh[7]}}, sh[7:0]};
            OP_LBU:  return {24'd0, sh[7:0]};
            OP_LH:   return {{16{sh[15]}}, sh[15:0]};
            OP_LHU:  return {16'd0, sh[15:0]};
            OP_LW:   return w;
            default: return '0;
        endcase
    endfunction

    task automatic check_value(input string name, input word_t actual, input word_t expected);
        checks++;
        if (actual !== expected)
        begin
            errors++;
            $display("error at %0d ns: %s is %h, expected %h", $time, name, actual, expected);
        end
    endtask

    task automatic begin_test();
        test_start = errors;
    endtask

    task automatic report_test(input string name);
        tests_run++;
        $display("test %s finished with %0d mismatches", name, errors - test_start);
    endtask

    task automatic randomize_slots();
        for (int i = 0; i < 2; i++)
        begin
            slots[i]             = '0;
            slots[i].pcplus4     = rand_word(30) << 2;
            slots[i].pcbranch    = rand_word(30) << 2;
            slots[i].pcjump      = rand_word(30) << 2;
            slots[i].srca        = rand_word(32);
            slots[i].destreg     = reg_addr_t'(rand_word(5));
            slots[i].exec_result = rand_word(32);
        end
        cp0_epc = rand_word(30) << 2;
    endtask

    task automatic test_load_format();
        mem_op_t ops [5];
        word_t   w;
        word_t   base;
        int      ms;
        int      stride;
        ops = '{OP_LB, OP_LBU, OP_LH, OP_LHU, OP_LW};
        begin_test();
        for (int s = 0; s < 2; s++)
        begin
            ms = 1 - s;
            for (int n = 0; n < 8; n++)
            begin
                w    = rand_word(32);
                base = rand_word(32) & 32'hffff_fffc;
                for (int k = 0; k < 5; k++)
                begin
                    stride = (ops[k] == OP_LW) ? 4 :
                             ((ops[k] == OP_LH || ops[k] == OP_LHU) ? 2 : 1);
                    for (int off = 0; off < 4; off += stride)
                    begin
                        @(negedge clk);
                        randomize_slots();
                        slots[ms].ctl.memtoreg = 1'b1;
                        slots[ms].ctl.regwrite = 1'b1;
                        slots[ms].ctl.mem_op   = ops[k];
                        stall = 1'b0;
                        mem   = '0;
                        mem.en      = 1'b1;
                        mem.data_ok = 1'b1;
                        mem.rdata   = w;
                        mem.addr    = base | word_t'(off);
                        #(SETTLE);
                        check_value("bypass.result", bypass.result[ms],
                                    expect_load(w, off, ops[k]));
                        check_value("bypass.ready", word_t'(bypass.ready[ms]), 32'd1);
                        check_value("bypass.result other", bypass.result[1 - ms],
                                    slots[1 - ms].exec_result);
                    end
                end
            end
        end
        report_test("load format");
    endtask

    // kind picks the expected target
    // 0 none, 1 exception, 2 epc, 3 slot0 pc+4, 4 pcbranch, 5 srca, 6 slot1 pc+4
    task automatic redirect_case(input logic exc, input logic eret1, input logic eret0,
                                 input logic br, input logic pt, input logic act,
                                 input logic jr, input logic jr_hit, input logic tlb,
                                 input int kind);
        word_t exp_target;
        @(negedge clk);
        randomize_slots();
        mem                   = '0;
        exception_valid       = exc;
        slots[1].ctl.eret     = eret1;
        slots[0].ctl.eret     = eret0;
        slots[1].ctl.branch   = br;
        slots[1].pred.taken   = pt;
        slots[1].taken        = act;
        slots[1].ctl.jr       = jr;
        slots[1].pred.destpc  = jr_hit ? slots[1].srca : slots[1].srca + 32'd8;
        slots[1].ctl.tlb      = tlb;
        #(SETTLE);
        case (kind)
            1:       exp_target = EXC_ENTRY;
            2:       exp_target = cp0_epc;
            3:       exp_target = slots[0].pcplus4;
            4:       exp_target = slots[1].pcbranch;
            5:       exp_target = slots[1].srca;
            6:       exp_target = slots[1].pcplus4;
            default: exp_target = '0;
        endcase
        check_value("redirect.valid", word_t'(redirect.valid), word_t'(kind != 0));
        if (kind != 0)
            check_value("redirect.target", redirect.target, exp_target);
    endtask

    task automatic test_redirect_priority();
        begin_test();
        redirect_case(1, 1, 0, 0, 0, 0, 0, 0, 1, 1);
        redirect_case(0, 0, 1, 1, 0, 1, 0, 0, 0, 2);
        redirect_case(0, 1, 0, 0, 0, 0, 0, 0, 1, 2);
        redirect_case(0, 0, 0, 1, 1, 0, 0, 0, 1, 3);
        redirect_case(0, 0, 0, 1, 0, 1, 0, 0, 0, 4);
        redirect_case(0, 0, 0, 1, 1, 1, 0, 0, 0, 0);
        redirect_case(0, 0, 0, 1, 0, 0, 0, 0, 0, 0);
        redirect_case(0, 0, 0, 0, 0, 0, 1, 1, 0, 5);
        redirect_case(0, 0, 0, 0, 1, 0, 1, 0, 1, 5);
        redirect_case(0, 0, 0, 0, 1, 0, 1, 1, 0, 0);
        redirect_case(0, 0, 0, 0, 0, 0, 0, 0, 1, 6);
        redirect_case(0, 0, 0, 0, 0, 0, 0, 0, 0, 0);
        report_test("redirect priority");
    endtask

    task automatic test_predictor_update();
        begin_test();
        for (int n = 0; n < 16; n++)
        begin
            @(negedge clk);
            randomize_slots();
            slots[1].ctl.branch = next_bit();
            slots[1].ctl.jump   = next_bit();
            slots[1].ctl.tlb    = next_bit();
            slots[1].taken      = next_bit();
            #(SETTLE);
            check_value("bpu_update.wen", word_t'(bpu_update.wen), word_t'(slots[1].ctl.branch));
            check_value("bpu_update.pc", bpu_update.pc, slots[1].pcplus4 - 32'd4);
            check_value("bpu_update.taken", word_t'(bpu_update.taken), word_t'(slots[1].taken));
            check_value("bpu_update.target", bpu_update.target,
                        slots[1].ctl.jump ? slots[1].pcjump : slots[1].pcbranch);
            check_value("tlb_ex", word_t'(tlb_ex), word_t'(slots[1].ctl.tlb));
        end
        report_test("predictor update");
    endtask

    task automatic test_held_response();
        word_t held;
        begin_test();
        held = rand_word(32);
        // load issued and memory not answered yet
        @(negedge clk);
        randomize_slots();
        slots[0].ctl.memtoreg = 1'b1;
        slots[0].ctl.regwrite = 1'b1;
        slots[0].ctl.mem_op   = OP_LW;
        mem      = '0;
        mem.en   = 1'b1;
        mem.addr = rand_word(30) << 2;
        stall    = 1'b1;
        #(SETTLE);
        check_value("finish_cdata", word_t'(finish_cdata), 32'd0);
        check_value("bypass.ready", word_t'(bypass.ready[0]), 32'd0);
        @(negedge clk);
        mem.data_ok = 1'b1;
        mem.rdata   = held;
        #(SETTLE);
        check_value("finish_cdata", word_t'(finish_cdata), 32'd1);
        check_value("bypass.result", bypass.result[0], held);
        // the pulse is gone; the stage keeps stalling
        for (int n = 0; n < 4; n++)
        begin
            @(negedge clk);
            mem.data_ok = 1'b0;
            mem.rdata   = rand_word(32);
            stall       = (n < 3);
            #(SETTLE);
            check_value("finish_cdata", word_t'(finish_cdata), 32'd1);
            check_value("bypass.ready", word_t'(bypass.ready[0]), 32'd1);
            check_value("bypass.result", bypass.result[0], held);
        end
        @(negedge clk);
        #(SETTLE);
        check_value("finish_cdata", word_t'(finish_cdata), 32'd0);
        check_value("bypass.ready", word_t'(bypass.ready[0]), 32'd0);
        report_test("held response");
    endtask

    task automatic test_pass_through();
        begin_test();
        for (int n = 0; n < 8; n++)
        begin
            @(negedge clk);
            randomize_slots();
            slots[1].ctl.regwrite = next_bit();
            slots[0].ctl.regwrite = next_bit();
            mem       = '0;
            mem.rdata = rand_word(32);
            stall     = 1'b0;
            #(SETTLE);
            check_value("finish_cdata", word_t'(finish_cdata), 32'd1);
            for (int i = 0; i < 2; i++)
            begin
                check_value("bypass.result", bypass.result[i], slots[i].exec_result);
                check_value("bypass.ready", word_t'(bypass.ready[i]), 32'd1);
                check_value("bypass.wen", word_t'(bypass.wen[i]), word_t'(slots[i].ctl.regwrite));
                check_value("bypass.destreg", word_t'(bypass.destreg[i]),
                            word_t'(slots[i].destreg));
            end
        end
        report_test("pass-through");
    endtask

    initial
    begin
        clk             = 1'b0;
        arst_n          = 1'b0;
        stall           = 1'b0;
        exception_valid = 1'b0;
        slots           = '0;
        cp0_epc         = '0;
        mem             = '0;
        lfsr            = 32'h9c98a957;
        errors          = 0;
        checks          = 0;
        tests_run       = 0;
        repeat (10) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
        test_load_format();
        test_redirect_priority();
        test_predictor_update();
        test_held_response();
        test_pass_through();
        $display("summary: %0d tests, %0d checks, %0d mismatches", tests_run, checks, errors);
        if (errors == 0)
            $display("No errors");
        else
            $display("Errors found");
        $finish;
    end

    initial
    begin
        #((TEST_CYCLES + MARGIN) * CLK_PERIOD);
        $display("watchdog: the tests did not finish in the expected time");
        $display("Errors found");
        $finish;
    end

endmodule

// ==== flist.f ====
hw/commit_pkg.sv
hw/load_format.sv
hw/mem_response_hold.sv
hw/redirect_unit.sv
hw/data_commit.sv
testbench/tb_data_commit.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the commit stage testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -sv -f flist.f --top-module tb_data_commit \
    -o tb_data_commit \
    && ./obj_dir/tb_data_commit > sim.log 2>&1 \
    || { echo "build or simulation failed"; cat sim.log 2>/dev/null; exit 1; }
cat sim.log
grep -q "^No errors$" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
